// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = z80PredecodeTb
FILELIST  = z80Predecode.f
OBJDIR    = obj_dir
LOG       = sim.log
SIMARGS   = +verilator+error+limit+100
PASSMSG   = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) $(SIMARGS) | tee $(LOG)
	@grep -q "^$(PASSMSG)$$" $(LOG) && echo "simulation passed" \
		|| (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: rtl/apbByteLoader.sv
`timescale 1ns/10ps

`include "z80Predecode_params.svh"

module apbByteLoader (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`Z80_APB_ADDR_W-1:0] paddr,
    input  logic [`Z80_BYTE_W-1:0]    pwdata,
    output logic [`Z80_BYTE_W-1:0]    prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      pushValid,
    output logic [`Z80_BYTE_W-1:0]    pushByte,
    input  logic                      full,
    input  logic [`Z80_LEVEL_W-1:0]   level
);

    logic setupPhase;
    logic accessPhase;
    logic dataWrite;
    logic statusRead;
    logic badAccess;

    assign setupPhase  = psel && !penable;
    assign accessPhase = psel && penable;

    // only two legal accesses exist
    assign dataWrite  = pwrite && (paddr == `Z80_ADDR_DATA);
    assign statusRead = !pwrite && (paddr == `Z80_ADDR_STATUS);
    assign badAccess  = !dataWrite && !statusRead;

    // data writes wait while the FIFO has no room
    assign pready  = accessPhase && !(dataWrite && full);
    assign pslverr = accessPhase && badAccess;

    assign pushValid = accessPhase && dataWrite && !full;
    assign pushByte  = pwdata;

    // level sampled in the setup phase, valid through the access phase
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prdata <= '0;
        end else if (setupPhase) begin
            if (statusRead) begin
                prdata <= {{(`Z80_BYTE_W - `Z80_LEVEL_W){1'b0}}, level};
            end else begin
                prdata <= '0;
            end
        end
    end

endmodule

// File: rtl/byteFifo.sv
`timescale 1ns/10ps

`include "z80Predecode_params.svh"

module byteFifo (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    pushValid,
    input  logic [`Z80_BYTE_W-1:0]  pushByte,
    output logic                    full,
    output logic [`Z80_LEVEL_W-1:0] level,
    input  logic                    popReq,
    output logic [`Z80_BYTE_W-1:0]  popByte,
    output logic                    empty
);

    localparam int PtrW = $clog2(`Z80_FIFO_DEPTH);

    logic [`Z80_BYTE_W-1:0] mem [`Z80_FIFO_DEPTH];
    logic [PtrW-1:0]        wrPtr;
    logic [PtrW-1:0]        rdPtr;
    logic                   doPush;
    logic                   doPop;

    assign full  = (level == `Z80_LEVEL_W'(`Z80_FIFO_DEPTH));
    assign empty = (level == '0);

    assign doPush = pushValid && !full;
    assign doPop  = popReq && !empty;

    // head entry straight from the array
    assign popByte = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushByte;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                level <= level + 1'b1;
            end else if (doPop && !doPush) begin
                level <= level - 1'b1;
            end
        end
    end

endmodule

// File: rtl/instrFramer.sv
`timescale 1ns/10ps

`include "z80Predecode_params.svh"

module instrFramer
    import z80PredecodePkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`Z80_BYTE_W-1:0] popByte,
    input  logic                   empty,
    output logic                   popReq,
    output logic                   insnValid,
    input  logic                   insnReady,
    output insnGroupT              insnGroup,
    output logic [`Z80_LEN_W-1:0]  insnLen,
    output logic [`Z80_REC_W-1:0]  insnBytes
);

    framerStateT            state;
    logic [`Z80_LEN_W-1:0]  byteCnt;
    logic [`Z80_BYTE_W-1:0] recBytes [`Z80_MAX_LEN];
    logic                   doPop;
    insnGroupT              clsGroup;
    logic [`Z80_LEN_W-1:0]  clsLen;
    logic [`Z80_BYTE_W-1:0] clsFirst;

    // opcode comes straight off the FIFO head in idle
    assign clsFirst = (state == idle) ? popByte : recBytes[0];

    opcodeClassifier u_classifier (
        .firstByte (clsFirst),
        .secondByte(popByte),
        .cbPhase   (state == prefix),
        .group     (clsGroup),
        .len       (clsLen)
    );

    assign popReq    = !empty && (state != present);
    assign doPop     = popReq;
    assign insnValid = (state == present);

    always_comb begin
        for (int i = 0; i < `Z80_MAX_LEN; i++) begin
            insnBytes[i*`Z80_BYTE_W +: `Z80_BYTE_W] = recBytes[i];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= idle;
            byteCnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (doPop) begin
                        byteCnt <= 2'd1;
                        if (clsGroup == needMoreBytes) begin
                            state <= prefix;
                        end else if (clsLen == 2'd1) begin
                            state <= present;
                        end else begin
                            state <= operands;
                        end
                    end
                end
                prefix: begin
                    if (doPop) begin
                        state <= present;
                    end
                end
                operands: begin
                    if (doPop) begin
                        byteCnt <= byteCnt + 2'd1;
                        if (byteCnt + 2'd1 == insnLen) begin
                            state <= present;
                        end
                    end
                end
                default: begin
                    if (insnReady) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    // record fields only change while a byte is being popped
    always_ff @(posedge clk) begin
        if (doPop) begin
            case (state)
                idle: begin
                    for (int i = 1; i < `Z80_MAX_LEN; i++) begin
                        recBytes[i] <= '0;
                    end
                    recBytes[0] <= popByte;
                    insnGroup   <= clsGroup;
                    insnLen     <= clsLen;
                end
                prefix: begin
                    recBytes[1] <= popByte;
                    insnGroup   <= clsGroup;
                    insnLen     <= clsLen;
                end
                default: recBytes[byteCnt] <= popByte;
            endcase
        end
    end

endmodule

// File: rtl/opcodeClassifier.sv
`timescale 1ns/10ps

`include "z80Predecode_params.svh"

module opcodeClassifier
    import z80PredecodePkg::*;
(
    input  logic [`Z80_BYTE_W-1:0] firstByte,
    input  logic [`Z80_BYTE_W-1:0] secondByte,
    input  logic                   cbPhase,
    output insnGroupT              group,
    output logic [`Z80_LEN_W-1:0]  len
);

    logic [`Z80_BYTE_W-1:0] op;
    logic [1:0]             opX;
    logic [2:0]             opY;
    logic [2:0]             opZ;
    logic                   indHl;

    // both tables split the opcode into x/y/z fields
    assign op    = cbPhase ? secondByte : firstByte;
    assign opX   = op[7:6];
    assign opY   = op[5:3];
    assign opZ   = op[2:0];
    assign indHl = (opZ == 3'd6);

    always_comb begin
        group = illegal;
        len   = 2'd1;
        if (cbPhase) begin
            len = 2'd2;
            case (opX)
                2'd0: begin
                    // rlc, rrc, rl, rr then the shifts
                    if (!opY[2]) begin
                        group = indHl ? rotIndHl : rotReg;
                    end else begin
                        group = indHl ? shiftIndHl : shiftReg;
                    end
                end
                2'd1: group = indHl ? bitIndHl : bitReg;
                2'd2: group = indHl ? resIndHl : resReg;
                default: group = indHl ? setIndHl : setReg;
            endcase
        end else begin
            case (opX)
                2'd0: begin
                    case (opZ)
                        3'd0: begin
                            if (opY == 3'd0) begin
                                group = nop;
                            end else if (opY == 3'd1) begin
                                group = exAfAf2;
                            end else begin
                                group = (opY == 3'd2) ? djnz : (opY == 3'd3) ? jr : jrCond;
                                len   = 2'd2;
                            end
                        end
                        3'd1: begin
                            group = opY[0] ? addHlDd : ldDdNn;
                            len   = opY[0] ? 2'd1 : 2'd3;
                        end
                        3'd2: begin
                            if (!opY[2]) begin
                                group = opY[0] ? ldAIndBcde : ldIndBcdeA;
                            end else begin
                                // direct address forms carry nn
                                case (opY[1:0])
                                    2'd0: group = ldIndNnHl;
                                    2'd1: group = ldHlIndNn;
                                    2'd2: group = ldIndNnA;
                                    default: group = ldAIndNn;
                                endcase
                                len = 2'd3;
                            end
                        end
                        3'd3: group = incDecDd;
                        3'd4, 3'd5: group = (opY == 3'd6) ? incDecIndHl : incDecReg;
                        3'd6: begin
                            group = (opY == 3'd6) ? ldIndHlN : ldRegN;
                            len   = 2'd2;
                        end
                        default: begin
                            case (opY)
                                3'd4: group = daa;
                                3'd5: group = cpl;
                                3'd6: group = scf;
                                3'd7: group = ccf;
                                default: group = rotA;
                            endcase
                        end
                    endcase
                end
                2'd1: begin
                    // ld r,(hl) is not part of the kept table
                    if (opY == 3'd6) begin
                        group = indHl ? halt : ldIndHlReg;
                    end else if (!indHl) begin
                        group = ldRegReg;
                    end
                end
                2'd2: group = indHl ? aluAIndHl : aluAReg;
                default: begin
                    case (opZ)
                        3'd0: group = retCond;
                        3'd1: begin
                            if (!opY[0]) begin
                                group = popQq;
                            end else begin
                                case (opY[2:1])
                                    2'd0: group = ret;
                                    2'd1: group = exx;
                                    2'd2: group = jpIndHl;
                                    default: group = ldSpHl;
                                endcase
                            end
                        end
                        3'd2: begin
                            group = jpCond;
                            len   = 2'd3;
                        end
                        3'd3: begin
                            case (opY)
                                3'd0: begin
                                    group = jp;
                                    len   = 2'd3;
                                end
                                3'd1: begin
                                    group = needMoreBytes;
                                    len   = 2'd2;
                                end
                                3'd2, 3'd3: begin
                                    group = opY[0] ? inA : outA;
                                    len   = 2'd2;
                                end
                                3'd4: group = exIndSpHl;
                                3'd5: group = exDeHl;
                                default: group = eiDi;
                            endcase
                        end
                        3'd4: begin
                            group = callCond;
                            len   = 2'd3;
                        end
                        3'd5: begin
                            if (!opY[0]) begin
                                group = pushQq;
                            end else if (opY[2:1] == 2'd0) begin
                                group = call;
                                len   = 2'd3;
                            end else begin
                                // DD, ED, FD
                                group = unsupportedPrefix;
                            end
                        end
                        3'd6: begin
                            group = aluAN;
                            len   = 2'd2;
                        end
                        default: group = rst;
                    endcase
                end
            endcase
        end
    end

endmodule

// File: rtl/z80Predecode.sv
`timescale 1ns/10ps

`include "z80Predecode_params.svh"

module z80Predecode
    import z80PredecodePkg::*;
(
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`Z80_APB_ADDR_W-1:0] paddr,
    input  logic [`Z80_BYTE_W-1:0]     pwdata,
    output logic [`Z80_BYTE_W-1:0]     prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       insnValid,
    input  logic                       insnReady,
    output insnGroupT                  insnGroup,
    output logic [`Z80_LEN_W-1:0]      insnLen,
    output logic [`Z80_REC_W-1:0]      insnBytes
);

    logic                    pushValid;
    logic [`Z80_BYTE_W-1:0]  pushByte;
    logic                    full;
    logic [`Z80_LEVEL_W-1:0] level;
    logic                    popReq;
    logic [`Z80_BYTE_W-1:0]  popByte;
    logic                    empty;

    apbByteLoader u_loader (
        .clk      (clk),
        .arstN    (arstN),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .pushValid(pushValid),
        .pushByte (pushByte),
        .full     (full),
        .level    (level)
    );

    byteFifo u_fifo (
        .clk      (clk),
        .arstN    (arstN),
        .pushValid(pushValid),
        .pushByte (pushByte),
        .full     (full),
        .level    (level),
        .popReq   (popReq),
        .popByte  (popByte),
        .empty    (empty)
    );

    instrFramer u_framer (
        .clk      (clk),
        .arstN    (arstN),
        .popByte  (popByte),
        .empty    (empty),
        .popReq   (popReq),
        .insnValid(insnValid),
        .insnReady(insnReady),
        .insnGroup(insnGroup),
        .insnLen  (insnLen),
        .insnBytes(insnBytes)
    );

endmodule

// File: rtl/z80PredecodePkg.sv
package z80PredecodePkg;

    // values count up from 0 in this order
    typedef enum logic [7:0] {
        nop,
        ldDdNn,
        ldIndBcdeA,
        incDecDd,
        incDecReg,
        rotA,
        addHlDd,
        daa,
        cpl,
        incDecIndHl,
        ldAIndBcde,
        ldRegN,
        ldIndNnHl,
        ldHlIndNn,
        ldIndHlN,
        ldRegReg,
        ldIndNnA,
        scf,
        ldAIndNn,
        ccf,
        ldIndHlReg,
        halt,
        jp,
        jpCond,
        jpIndHl,
        jr,
        jrCond,
        djnz,
        call,
        callCond,
        ret,
        retCond,
        rst,
        popQq,
        pushQq,
        exAfAf2,
        exIndSpHl,
        exDeHl,
        exx,
        ldSpHl,
        aluAReg,
        aluAIndHl,
        aluAN,
        eiDi,
        outA,
        inA,
        // CB-prefixed groups
        rotReg,
        rotIndHl,
        shiftReg,
        shiftIndHl,
        bitReg,
        bitIndHl,
        setReg,
        setIndHl,
        resReg,
        resIndHl,
        needMoreBytes,
        unsupportedPrefix,
        illegal
    } insnGroupT;

    typedef enum logic [1:0] {
        idle,
        prefix,
        operands,
        present
    } framerStateT;

endpackage

// File: rtl/z80Predecode_params.svh
`ifndef Z80_PREDECODE_PARAMS_SVH
`define Z80_PREDECODE_PARAMS_SVH

// program byte and FIFO sizing
`define Z80_BYTE_W 8
`define Z80_FIFO_DEPTH 8
`define Z80_LEVEL_W 4

// instruction record
`define Z80_MAX_LEN 3
`define Z80_LEN_W 2
`define Z80_REC_W 24

// APB register map
`define Z80_APB_ADDR_W 4
`define Z80_ADDR_DATA 4'h0
`define Z80_ADDR_STATUS 4'h4

`endif

// File: verification/z80PredecodeTb.sv
`timescale 1ns/10ps

`include "z80Predecode_params.svh"

module z80PredecodeTb
    import z80PredecodePkg::*;
();

    logic                       clk = 1'b0;
    logic                       arstN;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`Z80_APB_ADDR_W-1:0] paddr;
    logic [`Z80_BYTE_W-1:0]     pwdata;
    logic [`Z80_BYTE_W-1:0]     prdata;
    logic                       pready;
    logic                       pslverr;
    logic                       insnValid;
    logic                       insnReady = 1'b0;
    insnGroupT                  insnGroup;
    logic [`Z80_LEN_W-1:0]      insnLen;
    logic [`Z80_REC_W-1:0]      insnBytes;

    // stimulus ops in file order, expected records in arrival order
    byte                   opKind[$];
    int                    opArg[$];
    string                 testNames[$];
    int                    expPerTest[$];
    int                    gotPerTest[$];
    int                    errPerTest[$];
    insnGroupT             expGroupQ[$];
    logic [`Z80_LEN_W-1:0] expLenQ[$];
    logic [`Z80_REC_W-1:0] expBytesQ[$];
    int                    expTestQ[$];

    int seed = 32'h24c6c4a1;
    int vecLines = 0;
    int curTest = -1;
    int errorCount = 0;
    int recordCount = 0;
    int holdCycles = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    z80Predecode dut (
        .clk      (clk),
        .arstN    (arstN),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .insnValid(insnValid),
        .insnReady(insnReady),
        .insnGroup(insnGroup),
        .insnLen  (insnLen),
        .insnBytes(insnBytes)
    );

    always #10 clk = ~clk;

    function automatic void countError(input int t);
        errorCount++;
        if (t >= 0) begin
            errPerTest[t]++;
        end
    endfunction

    task automatic readVectors();
        int    fd;
        string line;
        string name;
        byte   kind;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        int    t;
        t = -1;
        fd = $fopen("verification/z80Predecode_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file, no stimulus was run");
            errorCount++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                vecLines++;
                kind = line.getc(0);
                case (kind)
                    "T": begin
                        void'($sscanf(line, "%c %s", kind, name));
                        testNames.push_back(name);
                        expPerTest.push_back(0);
                        gotPerTest.push_back(0);
                        errPerTest.push_back(0);
                        t = testNames.size() - 1;
                        opKind.push_back(kind);
                        opArg.push_back(t);
                    end
                    "W", "X": begin
                        void'($sscanf(line, "%c %h", kind, a));
                        opKind.push_back(kind);
                        opArg.push_back(a);
                    end
                    "S", "H": begin
                        void'($sscanf(line, "%c %d", kind, a));
                        opKind.push_back(kind);
                        opArg.push_back(a);
                    end
                    "E": begin
                        void'($sscanf(line, "%c %d %d %h %h %h", kind, a, b, c, d, e));
                        expGroupQ.push_back(insnGroupT'(a[7:0]));
                        expLenQ.push_back(b[`Z80_LEN_W-1:0]);
                        expBytesQ.push_back({e[7:0], d[7:0], c[7:0]});
                        expTestQ.push_back(t);
                        expPerTest[t]++;
                    end
                    default: begin
                        $display("Vector line not understood: %s", line);
                        errorCount++;
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    task automatic checkApb(
        input logic [`Z80_BYTE_W-1:0] gotData,
        input logic                   gotErr,
        input logic [`Z80_BYTE_W-1:0] expData,
        input logic                   expErr,
        input logic                   useData,
        input string                  what
    );
        if (gotErr !== expErr || (useData && gotData !== expData)) begin
            $display("[FAIL] %0t: %s gave prdata %h pslverr %b, expected prdata %h pslverr %b",
                $time, what, gotData, gotErr, expData, expErr);
            countError(curTest);
        end
    endtask

    task automatic checkRecord(
        input insnGroupT             gotGroup,
        input logic [`Z80_LEN_W-1:0] gotLen,
        input logic [`Z80_REC_W-1:0] gotBytes,
        input insnGroupT             expGroup,
        input logic [`Z80_LEN_W-1:0] expLen,
        input logic [`Z80_REC_W-1:0] expBytes,
        input int                    t
    );
        if (gotGroup !== expGroup || gotLen !== expLen || gotBytes !== expBytes) begin
            $display("[FAIL] %0t: %s record was %s len %0d bytes %h, expected %s len %0d bytes %h",
                $time, testNames[t], gotGroup.name(), gotLen, gotBytes,
                expGroup.name(), expLen, expBytes);
            countError(t);
        end
    endtask

    // setup on one falling edge, access on the next, done on the edge with pready
    task automatic apbTransfer(
        input  logic                       write,
        input  logic [`Z80_APB_ADDR_W-1:0] addr,
        input  logic [`Z80_BYTE_W-1:0]     data,
        output logic [`Z80_BYTE_W-1:0]     rdata,
        output logic                       err
    );
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) begin
            @(posedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic finishTest(input int t);
        while (gotPerTest[t] < expPerTest[t]) begin
            @(posedge clk);
        end
        if (errPerTest[t] == 0) begin
            $display("test %s: passed, %0d records", testNames[t], gotPerTest[t]);
        end else begin
            $display("test %s: failed, %0d errors", testNames[t], errPerTest[t]);
        end
    endtask

    task automatic takeRecord();
        int t;
        if (expGroupQ.size() == 0) begin
            $display("Record %s arrived at %0t when none was expected", insnGroup.name(), $time);
            countError(curTest);
        end else begin
            t = expTestQ.pop_front();
            checkRecord(insnGroup, insnLen, insnBytes,
                expGroupQ.pop_front(), expLenQ.pop_front(), expBytesQ.pop_front(), t);
            gotPerTest[t]++;
            recordCount++;
        end
    endtask

    // consumer side, randomly not ready unless a hold is running
    always @(negedge clk) begin
        int r;
        r = $random(seed);
        if (!arstN || holdCycles > 0) begin
            insnReady = 1'b0;
        end else begin
            insnReady = (r[1:0] != 2'b00);
        end
        if (holdCycles > 0) begin
            holdCycles--;
        end
    end

    always @(posedge clk) begin
        if (arstN && insnValid && insnReady) begin
            takeRecord();
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Run timed out after %0d cycles without the DUT finishing", cycleCount);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        logic [`Z80_BYTE_W-1:0] rdata;
        logic                   err;
        int                     arg;
        int                     r;
        arstN   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        readVectors();
        cycleLimit = 40 * vecLines + 200;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        foreach (opKind[i]) begin
            arg = opArg[i];
            case (opKind[i])
                "T": begin
                    if (curTest >= 0) begin
                        finishTest(curTest);
                    end
                    curTest = arg;
                end
                "W": begin
                    apbTransfer(1'b1, `Z80_ADDR_DATA, arg[7:0], rdata, err);
                    checkApb(rdata, err, 8'h00, 1'b0, 1'b0, "data write");
                    // idle gap of up to three cycles
                    r = $random(seed);
                    repeat (r & 3) @(negedge clk);
                end
                "S": begin
                    apbTransfer(1'b0, `Z80_ADDR_STATUS, 8'h00, rdata, err);
                    checkApb(rdata, err, arg[7:0], 1'b0, 1'b1, "status read");
                end
                "X": begin
                    // data register is write-only, everything else is not writable
                    if (arg[3:0] == `Z80_ADDR_DATA) begin
                        apbTransfer(1'b0, arg[3:0], 8'h00, rdata, err);
                    end else begin
                        apbTransfer(1'b1, arg[3:0], 8'hAA, rdata, err);
                    end
                    checkApb(rdata, err, 8'h00, 1'b1, 1'b0, "illegal access");
                end
                default: holdCycles = arg;
            endcase
        end
        if (curTest >= 0) begin
            finishTest(curTest);
        end
        $display("%0d tests, %0d records, %0d check errors, %0d assertion failures",
            testNames.size(), recordCount, errorCount, dut.u_checks.failCount);
        if (errorCount == 0 && dut.u_checks.failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verification/z80Predecode_assertions.sv
`timescale 1ns/10ps

`include "z80Predecode_params.svh"

module z80PredecodeAssertions
    import z80PredecodePkg::*;
(
    input logic                       clk,
    input logic                       arstN,
    input logic                       psel,
    input logic                       penable,
    input logic                       pwrite,
    input logic [`Z80_APB_ADDR_W-1:0] paddr,
    input logic [`Z80_BYTE_W-1:0]     pwdata,
    input logic                       pready,
    input logic                       full,
    input logic [`Z80_LEVEL_W-1:0]    level,
    input logic                       insnValid,
    input logic                       insnReady,
    input insnGroupT                  insnGroup,
    input logic [`Z80_LEN_W-1:0]      insnLen,
    input logic [`Z80_REC_W-1:0]      insnBytes
);

    int failCount = 0;

    // a transfer in a wait state keeps its address, direction and data
    apbHeld: assert property (@(posedge clk) disable iff (!arstN)
        (psel && penable && !pready) |=>
            (psel && penable && $stable(pwrite) && $stable(paddr) && $stable(pwdata)))
        else begin
            failCount++;
            $error("APB transfer changed while pready was low");
        end

    recordHeld: assert property (@(posedge clk) disable iff (!arstN)
        (insnValid && !insnReady) |=>
            (insnValid && $stable(insnGroup) && $stable(insnLen) && $stable(insnBytes)))
        else begin
            failCount++;
            $error("instruction record changed before it was taken");
        end

    // a push into a full FIFO would take the level past its depth
    noPushWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        full |=> (level <= `Z80_FIFO_DEPTH))
        else begin
            failCount++;
            $error("byte pushed into a full FIFO");
        end

endmodule

bind z80Predecode z80PredecodeAssertions u_checks (
    .clk      (clk),
    .arstN    (arstN),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .pready   (pready),
    .full     (full),
    .level    (level),
    .insnValid(insnValid),
    .insnReady(insnReady),
    .insnGroup(insnGroup),
    .insnLen  (insnLen),
    .insnBytes(insnBytes)
);

// File: verification/z80Predecode_vectors.txt
# T name | W byte(hex) | E group(dec) len(dec) b0 b1 b2(hex) | S status level(dec)
# X illegal access address(hex) | H cycles(dec) with insnReady held low
T oneByte
S 0
W 00
E 0 1 00 00 00
W 41
E 15 1 41 00 00
W 80
E 40 1 80 00 00
W FF
E 32 1 FF 00 00
W 76
E 21 1 76 00 00
T operands
W 01
W 34
W 12
E 1 3 01 34 12
W C3
W CD
W AB
E 22 3 C3 CD AB
W 20
W FE
E 26 2 20 FE 00
W 3E
W 55
E 11 2 3E 55 00
W C6
W 07
E 42 2 C6 07 00
W D3
W 10
E 44 2 D3 10 00
T cbPrefix
W CB
W 00
E 46 2 CB 00 00
W CB
W 06
E 47 2 CB 06 00
W CB
W 20
E 48 2 CB 20 00
W CB
W 3E
E 49 2 CB 3E 00
W CB
W 47
E 50 2 CB 47 00
W CB
W 46
E 51 2 CB 46 00
W CB
W C0
E 52 2 CB C0 00
W CB
W FE
E 53 2 CB FE 00
W CB
W 80
E 54 2 CB 80 00
W CB
W 86
E 55 2 CB 86 00
T prefixes
W ED
E 57 1 ED 00 00
W 00
E 0 1 00 00 00
W DD
E 57 1 DD 00 00
W 21
W 34
W 12
E 1 3 21 34 12
W FD
E 57 1 FD 00 00
W 7E
E 58 1 7E 00 00
T stall
H 120
W 00
E 0 1 00 00 00
W 3E
W 11
E 11 2 3E 11 00
W 06
W 22
E 11 2 06 22 00
W 0E
W 33
E 11 2 0E 33 00
W 16
W 44
E 11 2 16 44 00
S 8
W 76
E 21 1 76 00 00
T badAccess
X 0
X 4
W 2F
E 8 1 2F 00 00

// File: z80Predecode.f
+incdir+rtl
rtl/z80PredecodePkg.sv
rtl/apbByteLoader.sv
rtl/byteFifo.sv
rtl/opcodeClassifier.sv
rtl/instrFramer.sv
rtl/z80Predecode.sv
verification/z80Predecode_assertions.sv
verification/z80PredecodeTb.sv
